//--- rtl/aes_pkg.sv
// AES-128 shared definitions
// Mode and selector codes, FSM states and the control word
// passed from the control unit to the datapath and key schedule
package aes_pkg;

// ==============================
// Data and round count
// ==============================
typedef logic [127:0] block_t;

localparam int NUM_ROUNDS = 10;

// Chaining modes
typedef enum logic [1:0] {
	ECB = 2'b00,
	CBC = 2'b01,
	CTR = 2'b10
} aes_mode_t;

// S-box source, a state column or the g function
typedef enum logic [2:0] {
	COL_0      = 3'b000,
	COL_1      = 3'b001,
	COL_2      = 3'b010,
	COL_3      = 3'b011,
	G_FUNCTION = 3'b100
} sbox_sel_t;

// Source written into enabled state columns
typedef enum logic [1:0] {
	SHIFT_ROWS = 2'b00,
	ADD_RK_OUT = 2'b01,
	INPUT      = 2'b10
} col_sel_t;

// ==============================
// Round FSM
// ==============================
typedef enum logic [3:0] {
	IDLE        = 4'd0,
	ROUND0_COL0 = 4'd1,
	ROUND0_COL1 = 4'd2,
	ROUND0_COL2 = 4'd3,
	ROUND0_COL3 = 4'd4,
	ROUND_KEY0  = 4'd5,
	ROUND_COL0  = 4'd6,
	ROUND_COL1  = 4'd7,
	ROUND_COL2  = 4'd8,
	ROUND_COL3  = 4'd9,
	READY       = 4'd10
} aes_state_t;

// Control word, one per clock
typedef struct packed {
	sbox_sel_t  sbox_sel;
	col_sel_t   col_sel;
	logic [3:0] col_en;
	logic [3:0] key_en;
	logic [1:0] key_word_sel;
	// Round 0, plain key XOR
	logic       bypass_sbox;
	// No MixColumns
	logic       last_round;
	// Load host key, restart rcon
	logic       key_init;
} aes_ctrl_t;

// Multiply by x in GF(2^8)
function automatic logic [7:0] xtime(input logic [7:0] b);
	return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

endpackage

//--- rtl/aes_sbox.sv
// AES forward S-box
// One byte in, one byte out, FIPS-197 table lookup
`timescale 1ns/1ps
module aes_sbox
(
	input  logic [7:0] in,
	output logic [7:0] out
);

// Row n holds entries 16n to 16n+15, entry 0 at the MSB end
localparam logic [0:255][7:0] SBOX = {
	128'h637c777bf26b6fc53001672bfed7ab76,
	128'hca82c97dfa5947f0add4a2af9ca472c0,
	128'hb7fd9326363ff7cc34a5e5f171d83115,
	128'h04c723c31896059a071280e2eb27b275,
	128'h09832c1a1b6e5aa0523bd6b329e32f84,
	128'h53d100ed20fcb15b6acbbe394a4c58cf,
	128'hd0efaafb434d338545f9027f503c9fa8,
	128'h51a3408f929d38f5bcb6da2110fff3d2,
	128'hcd0c13ec5f974417c4a77e3d645d1973,
	128'h60814fdc222a908846eeb814de5e0bdb,
	128'he0323a0a4906245cc2d3ac629195e479,
	128'he7c8376d8dd54ea96c56f4ea657aae08,
	128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
	128'h703eb5664803f60e613557b986c11d9e,
	128'he1f8981169d98e949b1e87e9ce5528df,
	128'h8ca1890dbfe6426841992d0fb054bb16
};

// Pure lookup
assign out = SBOX[in];

endmodule

//--- rtl/aes_control_unit.sv
// AES-128 control unit
// Round FSM and round counter, one state column per clock
// Initial AddRoundKey, then ten rounds of key word plus four columns
`timescale 1ns/1ps
module aes_control_unit
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	output aes_pkg::aes_ctrl_t ctrl,
	output logic               end_comp
);
import aes_pkg::*;

aes_state_t state;
aes_state_t next_state;
logic [3:0] rd_count;
logic       rd_count_en;
logic [1:0] col_idx;
logic       last_round;

// ==============================
// State and round counter
// ==============================
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		state <= IDLE;
	else
		state <= next_state;
end

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		rd_count <= 4'd0;
	else if (state == IDLE)
		rd_count <= 4'd0;
	else if (rd_count_en)
		rd_count <= rd_count + 4'd1;
end

assign last_round = (rd_count == 4'(NUM_ROUNDS));
assign end_comp   = (state == READY);

// Column handled by the current column state
always_comb
begin
	if (state inside {ROUND0_COL0, ROUND0_COL1, ROUND0_COL2, ROUND0_COL3})
		col_idx = 2'(state - ROUND0_COL0);
	else
		col_idx = 2'(state - ROUND_COL0);
end

// Next state
always_comb
begin
	next_state = state;
	case (state)
		IDLE:
			if (start)
				next_state = ROUND0_COL0;
		ROUND0_COL0: next_state = ROUND0_COL1;
		ROUND0_COL1: next_state = ROUND0_COL2;
		ROUND0_COL2: next_state = ROUND0_COL3;
		ROUND0_COL3: next_state = ROUND_KEY0;
		ROUND_KEY0:  next_state = ROUND_COL0;
		ROUND_COL0:  next_state = ROUND_COL1;
		ROUND_COL1:  next_state = ROUND_COL2;
		ROUND_COL2:  next_state = ROUND_COL3;
		// Last round ends the block
		ROUND_COL3:  next_state = last_round ? READY : ROUND_KEY0;
		READY:       next_state = IDLE;
		default:     next_state = IDLE;
	endcase
end

// ==============================
// Control word
// ==============================
always_comb
begin
	ctrl            = '0;
	rd_count_en     = 1'b0;
	ctrl.last_round = last_round;
	case (state)
		IDLE:
		begin
			// Block and key loaded together on start
			if (start)
			begin
				ctrl.key_init = 1'b1;
				ctrl.col_sel  = INPUT;
				ctrl.col_en   = 4'b1111;
			end
		end
		ROUND0_COL0, ROUND0_COL1, ROUND0_COL2, ROUND0_COL3:
		begin
			// Column XOR host key word
			ctrl.sbox_sel     = sbox_sel_t'({1'b0, col_idx});
			ctrl.col_sel      = ADD_RK_OUT;
			ctrl.col_en       = 4'b0001 << col_idx;
			ctrl.key_word_sel = col_idx;
			ctrl.bypass_sbox  = 1'b1;
		end
		ROUND_KEY0:
		begin
			// g function on the S-boxes while the state shifts rows
			ctrl.sbox_sel = G_FUNCTION;
			ctrl.key_en   = 4'b0001;
			ctrl.col_sel  = SHIFT_ROWS;
			ctrl.col_en   = 4'b1111;
			rd_count_en   = 1'b1;
		end
		ROUND_COL0, ROUND_COL1, ROUND_COL2, ROUND_COL3:
		begin
			ctrl.sbox_sel     = sbox_sel_t'({1'b0, col_idx});
			ctrl.col_sel      = ADD_RK_OUT;
			ctrl.col_en       = 4'b0001 << col_idx;
			ctrl.key_word_sel = col_idx;
			// Expand next key word one step ahead of its use
			if (col_idx != 2'd3)
				ctrl.key_en = 4'b0010 << col_idx;
		end
		default: ;
	endcase
end

// Only whole-state loads touch all columns at once
a_enable_shape: assert property (@(posedge clk) disable iff (!rst_n)
	$onehot0(ctrl.key_en) &&
	($onehot0(ctrl.col_en) || ctrl.col_sel != ADD_RK_OUT));

a_round_range: assert property (@(posedge clk) disable iff (!rst_n)
	rd_count <= 4'(NUM_ROUNDS));

a_end_pulse: assert property (@(posedge clk) disable iff (!rst_n)
	end_comp |=> !end_comp);

endmodule

//--- rtl/aes_key_schedule.sv
// AES-128 key schedule
// Four round key words expanded on the fly, one word per clock
// g function uses the datapath S-boxes through sbox_word
`timescale 1ns/1ps
module aes_key_schedule
(
	input  logic               clk,
	input  logic               rst_n,
	input  aes_pkg::aes_ctrl_t ctrl,
	input  aes_pkg::block_t    key,
	input  logic [31:0]        sbox_word,
	output logic [31:0]        rk_word,
	output logic [31:0]        rot_word
);
import aes_pkg::*;

// w_q[0] is the first word of the key
logic [0:3][31:0] w_q;
logic [7:0]       rcon_q;

assign rk_word  = w_q[ctrl.key_word_sel];
// RotWord of w3, fed to the S-boxes
assign rot_word = {w_q[3][23:0], w_q[3][31:24]};

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
	begin
		w_q    <= '0;
		rcon_q <= 8'h01;
	end
	else if (ctrl.key_init)
	begin
		w_q    <= key;
		rcon_q <= 8'h01;
	end
	else
	begin
		// w0 takes SubWord(RotWord(w3)) and rcon
		if (ctrl.key_en[0])
		begin
			w_q[0] <= w_q[0] ^ sbox_word ^ {rcon_q, 24'h000000};
			rcon_q <= xtime(rcon_q);
		end
		// Chain through the already updated predecessor
		for (int i = 1; i < 4; i++)
		begin
			if (ctrl.key_en[i])
				w_q[i] <= w_q[i] ^ w_q[i-1];
		end
	end
end

// Words expand alone and in order across a round
a_key_word_order: assert property (@(posedge clk) disable iff (!rst_n)
	ctrl.key_en == 4'b0001 |=> ctrl.key_en == 4'b0010
		##1 ctrl.key_en == 4'b0100 ##1 ctrl.key_en == 4'b1000);

endmodule

//--- rtl/aes_datapath.sv
// AES-128 column-serial datapath
// Four state columns, ShiftRows on the whole state,
// shared S-box column, MixColumns and AddRoundKey per column
`timescale 1ns/1ps
module aes_datapath
(
	input  logic               clk,
	input  logic               rst_n,
	input  aes_pkg::aes_ctrl_t ctrl,
	input  aes_pkg::block_t    block_in,
	input  logic [31:0]        rk_word,
	input  logic [31:0]        rot_word,
	output logic [31:0]        sbox_word,
	output aes_pkg::block_t    block_out
);
import aes_pkg::*;

// Bytes of one column, row 0 first
typedef logic [0:3][7:0] word_t;

word_t [0:3] st_q;
word_t [0:3] in_cols;
word_t [0:3] shifted;
word_t       sbox_in;
word_t       sbox_out;
word_t       ark_word;

// One MixColumns column
function automatic word_t mix_column(input word_t a);
	word_t b;
	for (int r = 0; r < 4; r++)
		b[r] = xtime(a[r]) ^ xtime(a[(r+1)%4]) ^ a[(r+1)%4] ^ a[(r+2)%4] ^ a[(r+3)%4];
	return b;
endfunction

assign in_cols   = block_in;
assign block_out = st_q;
assign sbox_word = sbox_out;

// ==============================
// Shared S-box column
// ==============================
assign sbox_in = (ctrl.sbox_sel == G_FUNCTION) ? word_t'(rot_word)
                                                : st_q[2'(ctrl.sbox_sel)];

for (genvar i = 0; i < 4; i++)
begin : g_sbox
	aes_sbox i_aes_sbox
	(
		.in  (sbox_in[i]),
		.out (sbox_out[i])
	);
end

// Row r rotates left by r columns
always_comb
begin
	for (int c = 0; c < 4; c++)
		for (int r = 0; r < 4; r++)
			shifted[c][r] = st_q[(c + r) % 4][r];
end

// Round 0 skips the S-box, last round skips MixColumns
always_comb
begin
	if (ctrl.bypass_sbox)
		ark_word = sbox_in ^ rk_word;
	else if (ctrl.last_round)
		ark_word = sbox_out ^ rk_word;
	else
		ark_word = mix_column(sbox_out) ^ rk_word;
end

// State columns
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		st_q <= '0;
	else
	begin
		for (int c = 0; c < 4; c++)
		begin
			if (ctrl.col_en[c])
			begin
				case (ctrl.col_sel)
					INPUT:      st_q[c] <= in_cols[c];
					SHIFT_ROWS: st_q[c] <= shifted[c];
					default:    st_q[c] <= ark_word;
				endcase
			end
		end
	end
end

endmodule

//--- rtl/aes_host_if.sv
// AES host interface
// Key and mode capture, one input slot, CBC chain and CTR counter
// Credit handshake on both sides, one block in flight
`timescale 1ns/1ps
module aes_host_if
#(
	parameter int OUT_CREDITS = 2
)
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               key_load,
	input  aes_pkg::block_t    key,
	input  aes_pkg::aes_mode_t mode,
	input  aes_pkg::block_t    iv,
	input  logic               in_valid,
	input  aes_pkg::block_t    in_data,
	output logic               in_credit,
	output logic               out_valid,
	output aes_pkg::block_t    out_data,
	input  logic               out_credit,
	output logic               start,
	input  logic               end_comp,
	output aes_pkg::block_t    block_to_core,
	input  aes_pkg::block_t    block_from_core,
	output aes_pkg::block_t    core_key
);
import aes_pkg::*;

localparam int CW = $clog2(OUT_CREDITS + 1);

aes_mode_t     mode_q;
block_t        key_q;
block_t        chain_q;
block_t        slot_q;
logic          slot_full;
logic          busy;
logic          credit_q;
logic          idle;
logic          launch;
logic [CW-1:0] out_cnt;

assign idle     = !busy && !slot_full;
// Slot full and somewhere to put the result
assign launch   = slot_full && !busy && (out_cnt != '0);
assign core_key = key_q;

// Core input per mode
always_comb
begin
	case (mode_q)
		CBC:     block_to_core = slot_q ^ chain_q;
		CTR:     block_to_core = chain_q;
		default: block_to_core = slot_q;
	endcase
end

// ==============================
// Handshake and credits
// ==============================
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
	begin
		mode_q    <= ECB;
		slot_full <= 1'b0;
		busy      <= 1'b0;
		credit_q  <= 1'b0;
		in_credit <= 1'b0;
		start     <= 1'b0;
		out_valid <= 1'b0;
		out_cnt   <= '0;
	end
	else
	begin
		if (key_load && idle)
			mode_q <= mode;
		// One grant per empty slot
		in_credit <= idle && !credit_q;
		if (idle && !credit_q)
			credit_q <= 1'b1;
		else if (in_valid)
			credit_q <= 1'b0;
		if (in_valid)
			slot_full <= 1'b1;
		else if (end_comp)
			slot_full <= 1'b0;
		start <= launch;
		if (launch)
			busy <= 1'b1;
		else if (end_comp)
			busy <= 1'b0;
		out_valid <= end_comp;
		// Returned credits saturate, each result spends one
		if (out_credit && !out_valid && out_cnt != CW'(OUT_CREDITS))
			out_cnt <= out_cnt + 1'b1;
		else if (out_valid && !out_credit)
			out_cnt <= out_cnt - 1'b1;
	end
end

// Payload registers
always_ff @(posedge clk)
begin
	if (key_load && idle)
	begin
		key_q   <= key;
		chain_q <= iv;
	end
	else if (end_comp)
	begin
		// CBC chains the ciphertext, CTR bumps the low word
		if (mode_q == CBC)
			chain_q <= block_from_core;
		else if (mode_q == CTR)
			chain_q[31:0] <= chain_q[31:0] + 32'd1;
	end
	if (in_valid)
		slot_q <= in_data;
	if (end_comp)
		out_data <= (mode_q == CTR) ? (block_from_core ^ slot_q) : block_from_core;
end

a_in_valid_credit: assert property (@(posedge clk) disable iff (!rst_n)
	in_valid |-> credit_q);

endmodule

//--- rtl/aes_core_top.sv
// AES-128 encryption core
// Host interface, round control unit, datapath and key schedule
`timescale 1ns/1ps
module aes_core_top
#(
	parameter int OUT_CREDITS = 2
)
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               key_load,
	input  aes_pkg::block_t    key,
	input  aes_pkg::aes_mode_t mode,
	input  aes_pkg::block_t    iv,
	input  logic               in_valid,
	input  aes_pkg::block_t    in_data,
	output logic               in_credit,
	output logic               out_valid,
	output aes_pkg::block_t    out_data,
	input  logic               out_credit
);
import aes_pkg::*;

aes_ctrl_t   ctrl;
logic        start;
logic        end_comp;
block_t      block_to_core;
block_t      block_from_core;
block_t      core_key;
logic [31:0] sbox_word;
logic [31:0] rk_word;
logic [31:0] rot_word;

aes_host_if #(
	.OUT_CREDITS (OUT_CREDITS)
) i_aes_host_if (
	.clk             (clk),
	.rst_n           (rst_n),
	.key_load        (key_load),
	.key             (key),
	.mode            (mode),
	.iv              (iv),
	.in_valid        (in_valid),
	.in_data         (in_data),
	.in_credit       (in_credit),
	.out_valid       (out_valid),
	.out_data        (out_data),
	.out_credit      (out_credit),
	.start           (start),
	.end_comp        (end_comp),
	.block_to_core   (block_to_core),
	.block_from_core (block_from_core),
	.core_key        (core_key)
);

aes_control_unit i_aes_control_unit (
	.clk      (clk),
	.rst_n    (rst_n),
	.start    (start),
	.ctrl     (ctrl),
	.end_comp (end_comp)
);

aes_datapath i_aes_datapath (
	.clk       (clk),
	.rst_n     (rst_n),
	.ctrl      (ctrl),
	.block_in  (block_to_core),
	.rk_word   (rk_word),
	.rot_word  (rot_word),
	.sbox_word (sbox_word),
	.block_out (block_from_core)
);

aes_key_schedule i_aes_key_schedule (
	.clk       (clk),
	.rst_n     (rst_n),
	.ctrl      (ctrl),
	.key       (core_key),
	.sbox_word (sbox_word),
	.rk_word   (rk_word),
	.rot_word  (rot_word)
);

endmodule

//--- tb/aes_tb.sv
// AES-128 core testbench
// Applies FIPS-197 and SP 800-38A vectors in ECB, CBC and CTR mode
// through the credit handshake with the first block under output back-pressure
`timescale 1ns/1ps
module aes_tb;
import aes_pkg::*;

localparam int OUT_CREDITS = 2;
localparam int NUM_ROWS    = 7;
localparam int HOLD_CYCLES = 100;

// One row of the vector table
typedef struct packed {
	logic      load;
	aes_mode_t mode;
	block_t    key;
	block_t    iv;
	block_t    plain;
	block_t    expected;
} vector_t;

// ==============================
// Vector table
// ==============================
localparam vector_t VECTORS [NUM_ROWS] = '{
	// FIPS-197 C.1
	'{1'b1, ECB, 128'h000102030405060708090a0b0c0d0e0f, 128'h0,
		128'h00112233445566778899aabbccddeeff, 128'h69c4e0d86a7b0430d8cdb78070b4c55a},
	// F.1.1 ECB with two blocks
	'{1'b1, ECB, 128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h0,
		128'h6bc1bee22e409f96e93d7e117393172a, 128'h3ad77bb40d7a3660a89ecaf32466ef97},
	'{1'b0, ECB, 128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h0,
		128'hae2d8a571e03ac9c9eb76fac45af8e51, 128'hf5d3d58503b9699de785895a96fdbaaf},
	// F.2.1 CBC where the second block chains on the first ciphertext
	'{1'b1, CBC, 128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h000102030405060708090a0b0c0d0e0f,
		128'h6bc1bee22e409f96e93d7e117393172a, 128'h7649abac8119b246cee98e9b12e9197d},
	'{1'b0, CBC, 128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h000102030405060708090a0b0c0d0e0f,
		128'hae2d8a571e03ac9c9eb76fac45af8e51, 128'h5086cb9b507219ee95db113a917678b2},
	// F.5.1 CTR with the counter low word stepping between blocks
	'{1'b1, CTR, 128'h2b7e151628aed2a6abf7158809cf4f3c, 128'hf0f1f2f3f4f5f6f7f8f9fafbfcfdfeff,
		128'h6bc1bee22e409f96e93d7e117393172a, 128'h874d6191b620e3261bef6864990db6ce},
	'{1'b0, CTR, 128'h2b7e151628aed2a6abf7158809cf4f3c, 128'hf0f1f2f3f4f5f6f7f8f9fafbfcfdfeff,
		128'hae2d8a571e03ac9c9eb76fac45af8e51, 128'h9806f66b7970fdff8617187bb9fffdff}
};

logic      clk = 1'b0;
logic      rst_n;
logic      key_load;
block_t    key;
aes_mode_t mode;
block_t    iv;
logic      in_valid;
block_t    in_data;
logic      in_credit;
logic      out_valid;
block_t    out_data;
logic      out_credit;

// Handshake bookkeeping
block_t results[$];
int     free_credits = 0;
int     in_flight    = 0;
int     held         = 0;
int     gap          = 0;
logic   credit_en    = 1'b0;
integer seed         = 6;

always #2 clk = ~clk;

aes_core_top #(
	.OUT_CREDITS (OUT_CREDITS)
) i_aes_core_top (
	.clk        (clk),
	.rst_n      (rst_n),
	.key_load   (key_load),
	.key        (key),
	.mode       (mode),
	.iv         (iv),
	.in_valid   (in_valid),
	.in_data    (in_data),
	.in_credit  (in_credit),
	.out_valid  (out_valid),
	.out_data   (out_data),
	.out_credit (out_credit)
);

task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
	if (got !== exp)
	begin
		$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		$display("Checks failed");
		$fatal(1);
	end
endtask

// ==============================
// One clock to sample then drive
// ==============================
task automatic next_cycle();
	@(negedge clk);
	in_valid = 1'b0;
	key_load = 1'b0;
	// A result spends one output credit
	if (out_valid)
	begin
		check("out_valid with a block in flight", in_flight > 0, 1'b1);
		results.push_back(out_data);
		in_flight--;
		held--;
	end
	// Core grants a single slot at a time
	if (in_credit)
	begin
		check("unused input credits at in_credit", free_credits, 0);
		free_credits++;
	end
	// Downstream returns credits after random gaps
	out_credit = 1'b0;
	if (gap > 0)
		gap--;
	else if (credit_en && held < OUT_CREDITS)
	begin
		out_credit = 1'b1;
		held++;
		gap = $unsigned($random(seed)) % 8;
	end
endtask

// Wait for a credit, reload the key if asked, then hand over one block
task automatic send_block(input vector_t v);
	while (free_credits == 0)
		next_cycle();
	if (v.load)
	begin
		key_load = 1'b1;
		key      = v.key;
		mode     = v.mode;
		iv       = v.iv;
		next_cycle();
	end
	in_valid = 1'b1;
	in_data  = v.plain;
	free_credits--;
	in_flight++;
endtask

// ==============================
// Stimulus loop
// ==============================
initial
begin
	block_t got;
	rst_n      = 1'b0;
	key_load   = 1'b0;
	key        = '0;
	mode       = ECB;
	iv         = '0;
	in_valid   = 1'b0;
	in_data    = '0;
	out_credit = 1'b0;
	repeat (3)
	begin
		@(negedge clk);
		check("in_credit", in_credit, 1'b0);
		check("out_valid", out_valid, 1'b0);
	end
	rst_n = 1'b1;
	for (int i = 0; i < NUM_ROWS; i++)
	begin
		send_block(VECTORS[i]);
		// First block waits in the slot with no output credit
		if (i == 0)
		begin
			repeat (HOLD_CYCLES)
				next_cycle();
			check("results under back-pressure", results.size(), 0);
			check("input credits under back-pressure", free_credits, 0);
			credit_en = 1'b1;
		end
		while (results.size() == 0)
			next_cycle();
		got = results.pop_front();
		check($sformatf("out_data row %0d", i), got, VECTORS[i].expected);
	end
	$display("All checks passed");
	$finish;
end

// Watchdog sized from the table length
initial
begin
	repeat (NUM_ROWS * 100 + 500)
		@(posedge clk);
	$display("Timeout at %0t ns, the DUT stopped returning results", $time);
	$display("Checks failed");
	$fatal(1);
end

endmodule

//--- tb.f
rtl/aes_pkg.sv
rtl/aes_sbox.sv
rtl/aes_control_unit.sv
rtl/aes_key_schedule.sv
rtl/aes_datapath.sv
rtl/aes_host_if.sv
rtl/aes_core_top.sv
tb/aes_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = aes_tb
FLIST = tb.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
